//--- Makefile
TOP = mem_access_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f mem_access.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mem_access.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- bios.hex
// One 32-bit boot ROM word per line, word index 0 to 15
00000013
80000537
fff50513
12345678
deadbeef
7f80ff01
00c58633
8000ffff
a5a55a5a
0000007f
ffff8000
13579bdf
fedcba98
01020304
c0ffee00
00000000

//--- mem_access.f
source/mem_access_pkg.sv
source/mem_access_ctrl.sv
source/byte_lane_align.sv
source/load_formatter.sv
source/data_ram.sv
source/boot_rom.sv
source/perf_counters.sv
source/mem_access_top.sv
verification/mem_access_checker.sv
verification/mem_access_tb.sv

//--- source/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  logic                  clk,
    input  logic                  en,
    input  mem_access_pkg::addr_t addr,
    output mem_access_pkg::word_t rdata
);
    mem_access_pkg::word_t mem [mem_access_pkg::ROM_WORDS];

    // Boot image
    initial begin
        $readmemh("bios.hex", mem);
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr[mem_access_pkg::ROM_IDX_W+1:2]];
        end
    end

endmodule

`default_nettype wire

//--- source/byte_lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_align (
    input  mem_access_pkg::addr_t    paddr,
    input  mem_access_pkg::funct3_t  funct3,
    input  mem_access_pkg::word_t    pwdata,
    output mem_access_pkg::byte_en_t lane_mask,
    output mem_access_pkg::word_t    store_data,
    output logic                     misaligned
);
    logic [1:0] ofs;

    assign ofs = paddr[1:0];

    // Store data moves up to the lane of the addressed byte
    assign store_data = pwdata << {ofs, 3'b000};

    always_comb begin
        lane_mask  = '0;
        misaligned = 1'b0;
        case (funct3)
            mem_access_pkg::F3_BYTE, mem_access_pkg::F3_BYTE_U: begin
                lane_mask = 4'b0001 << ofs;
            end
            mem_access_pkg::F3_HALF, mem_access_pkg::F3_HALF_U: begin
                misaligned = ofs[0];
                if (!ofs[0]) begin
                    lane_mask = 4'b0011 << ofs;
                end
            end
            mem_access_pkg::F3_WORD: begin
                misaligned = (ofs != 2'd0);
                if (ofs == 2'd0) begin
                    lane_mask = 4'b1111;
                end
            end
            default: misaligned = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     wr,
    input  mem_access_pkg::byte_en_t lane_mask,
    input  mem_access_pkg::addr_t    addr,
    input  mem_access_pkg::word_t    wdata,
    output mem_access_pkg::word_t    rdata
);
    mem_access_pkg::word_t mem [mem_access_pkg::DMEM_WORDS];

    logic [mem_access_pkg::DMEM_IDX_W-1:0] idx;

    assign idx = addr[mem_access_pkg::DMEM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (en && wr) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_mask[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end else if (en) begin
            rdata <= mem[idx];
        end
    end

    a_wr_needs_en: assert property (@(posedge clk) wr |-> en);

endmodule

`default_nettype wire

//--- source/load_formatter.sv
`timescale 1ns/1ps
`default_nettype none

module load_formatter (
    input  mem_access_pkg::read_src_t rd_src,
    input  mem_access_pkg::word_t     ram_rdata,
    input  mem_access_pkg::word_t     rom_rdata,
    input  mem_access_pkg::word_t     cnt_rdata,
    input  mem_access_pkg::addr_t     paddr,
    input  mem_access_pkg::funct3_t   funct3,
    output mem_access_pkg::word_t     prdata
);
    mem_access_pkg::word_t word;
    mem_access_pkg::word_t shifted;

    always_comb begin
        case (rd_src)
            mem_access_pkg::SRC_RAM: word = ram_rdata;
            mem_access_pkg::SRC_ROM: word = rom_rdata;
            mem_access_pkg::SRC_CNT: word = cnt_rdata;
            default:                 word = '0;
        endcase
    end

    // Addressed byte or halfword lands in the low lanes
    assign shifted = word >> {paddr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            mem_access_pkg::F3_BYTE:   prdata = {{24{shifted[7]}}, shifted[7:0]};
            mem_access_pkg::F3_HALF:   prdata = {{16{shifted[15]}}, shifted[15:0]};
            mem_access_pkg::F3_WORD:   prdata = shifted;
            mem_access_pkg::F3_BYTE_U: prdata = {24'h0, shifted[7:0]};
            mem_access_pkg::F3_HALF_U: prdata = {16'h0, shifted[15:0]};
            default:                   prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  mem_access_pkg::addr_t     paddr,
    input  logic                      misaligned,
    output logic                      ram_en,
    output logic                      ram_wr,
    output logic                      rom_en,
    output logic                      cnt_rd,
    output logic                      cnt_clear,
    output logic                      pready,
    output logic                      pslverr,
    output mem_access_pkg::read_src_t rd_src
);
    typedef enum logic {ACC_IDLE, ACC_READ_WAIT} acc_state_t;

    acc_state_t state;
    acc_state_t state_next;
    logic [3:0] region;
    logic       is_ram;
    logic       is_rom;
    logic       is_mmio;
    logic       access;
    logic       bad;

    assign region  = paddr[31:28];
    assign is_ram  = (region == mem_access_pkg::REGION_DMEM_A) ||
                     (region == mem_access_pkg::REGION_DMEM_B);
    assign is_rom  = (region == mem_access_pkg::REGION_BIOS);
    assign is_mmio = (region == mem_access_pkg::REGION_MMIO);
    assign access  = psel && penable;

    // Unmapped nibble, ROM write or bad alignment
    assign bad = misaligned || (pwrite && is_rom) || !(is_ram || is_rom || is_mmio);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ACC_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        ram_en     = 1'b0;
        ram_wr     = 1'b0;
        rom_en     = 1'b0;
        cnt_rd     = 1'b0;
        cnt_clear  = 1'b0;
        pready     = 1'b0;
        pslverr    = 1'b0;
        rd_src     = mem_access_pkg::SRC_NONE;
        case (state)
            ACC_IDLE: begin
                if (access && bad) begin
                    pready  = 1'b1;
                    pslverr = 1'b1;
                end else if (access && pwrite) begin
                    // Writes finish with no wait state
                    pready    = 1'b1;
                    ram_en    = is_ram;
                    ram_wr    = is_ram;
                    cnt_clear = is_mmio && (paddr[7:0] == mem_access_pkg::OFS_CLEAR);
                end else if (access) begin
                    ram_en     = is_ram;
                    rom_en     = is_rom;
                    cnt_rd     = is_mmio;
                    state_next = ACC_READ_WAIT;
                end
            end
            ACC_READ_WAIT: begin
                // Address is still held so the region picks the returned word
                pready     = access;
                state_next = ACC_IDLE;
                if (is_ram) begin
                    rd_src = mem_access_pkg::SRC_RAM;
                end else if (is_rom) begin
                    rd_src = mem_access_pkg::SRC_ROM;
                end else if (is_mmio) begin
                    rd_src = mem_access_pkg::SRC_CNT;
                end
            end
            default: state_next = ACC_IDLE;
        endcase
    end

    // Read decode relies on the master holding the address through the wait state
    a_addr_held: assert property (@(posedge clk) disable iff (rst)
        (state == ACC_READ_WAIT) |-> $stable(paddr));
    a_one_wait_state: assert property (@(posedge clk) disable iff (rst)
        (state == ACC_READ_WAIT) |-> pready);

endmodule

`default_nettype wire

//--- source/mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 32;

    // Data path types
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;
    typedef logic [2:0] funct3_t;
    typedef logic [1:0] read_src_t;

    // Load/store size codes in the RISC-V funct3 encoding
    localparam funct3_t F3_BYTE   = 3'd0;
    localparam funct3_t F3_HALF   = 3'd1;
    localparam funct3_t F3_WORD   = 3'd2;
    localparam funct3_t F3_BYTE_U = 3'd4;
    localparam funct3_t F3_HALF_U = 3'd5;

    // Upper address nibble of each region
    localparam logic [3:0] REGION_DMEM_A = 4'h1;
    localparam logic [3:0] REGION_DMEM_B = 4'h3;
    localparam logic [3:0] REGION_BIOS   = 4'h4;
    localparam logic [3:0] REGION_MMIO   = 4'h8;

    // Memory depths and word index widths
    localparam int DMEM_WORDS = 1024;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);
    localparam int ROM_WORDS  = 16;
    localparam int ROM_IDX_W  = $clog2(ROM_WORDS);

    // Counter I/O offsets within the MMIO region
    localparam logic [7:0] OFS_CYCLE   = 8'h10;
    localparam logic [7:0] OFS_RETIRE  = 8'h14;
    localparam logic [7:0] OFS_CLEAR   = 8'h18;
    localparam logic [7:0] OFS_BRANCH  = 8'h1C;
    localparam logic [7:0] OFS_PRED_OK = 8'h20;

    // Which registered word feeds the load formatter
    localparam read_src_t SRC_NONE = 2'd0;
    localparam read_src_t SRC_RAM  = 2'd1;
    localparam read_src_t SRC_ROM  = 2'd2;
    localparam read_src_t SRC_CNT  = 2'd3;

endpackage

`default_nettype wire

//--- source/mem_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  mem_access_pkg::addr_t   paddr,
    input  mem_access_pkg::word_t   pwdata,
    input  mem_access_pkg::funct3_t funct3,
    output mem_access_pkg::word_t   prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    retire,
    input  logic                    branch,
    input  logic                    branch_correct
);
    logic                      ram_en;
    logic                      ram_wr;
    logic                      rom_en;
    logic                      cnt_rd;
    logic                      cnt_clear;
    logic                      misaligned;
    mem_access_pkg::read_src_t rd_src;
    mem_access_pkg::byte_en_t  lane_mask;
    mem_access_pkg::word_t     store_data;
    mem_access_pkg::word_t     ram_rdata;
    mem_access_pkg::word_t     rom_rdata;
    mem_access_pkg::word_t     cnt_rdata;

    mem_access_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .misaligned (misaligned),
        .ram_en     (ram_en),
        .ram_wr     (ram_wr),
        .rom_en     (rom_en),
        .cnt_rd     (cnt_rd),
        .cnt_clear  (cnt_clear),
        .pready     (pready),
        .pslverr    (pslverr),
        .rd_src     (rd_src)
    );

    byte_lane_align u_align (
        .paddr      (paddr),
        .funct3     (funct3),
        .pwdata     (pwdata),
        .lane_mask  (lane_mask),
        .store_data (store_data),
        .misaligned (misaligned)
    );

    data_ram u_ram (
        .clk       (clk),
        .en        (ram_en),
        .wr        (ram_wr),
        .lane_mask (lane_mask),
        .addr      (paddr),
        .wdata     (store_data),
        .rdata     (ram_rdata)
    );

    boot_rom u_rom (
        .clk   (clk),
        .en    (rom_en),
        .addr  (paddr),
        .rdata (rom_rdata)
    );

    perf_counters u_counters (
        .clk            (clk),
        .rst            (rst),
        .retire         (retire),
        .branch         (branch),
        .branch_correct (branch_correct),
        .clear          (cnt_clear),
        .rd             (cnt_rd),
        .addr           (paddr),
        .rdata          (cnt_rdata)
    );

    load_formatter u_format (
        .rd_src    (rd_src),
        .ram_rdata (ram_rdata),
        .rom_rdata (rom_rdata),
        .cnt_rdata (cnt_rdata),
        .paddr     (paddr),
        .funct3    (funct3),
        .prdata    (prdata)
    );

endmodule

`default_nettype wire

//--- source/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retire,
    input  logic                  branch,
    input  logic                  branch_correct,
    input  logic                  clear,
    input  logic                  rd,
    input  mem_access_pkg::addr_t addr,
    output mem_access_pkg::word_t rdata
);
    mem_access_pkg::word_t cycle_cnt;
    mem_access_pkg::word_t retire_cnt;
    mem_access_pkg::word_t branch_cnt;
    mem_access_pkg::word_t pred_ok_cnt;
    mem_access_pkg::word_t cycle_next;
    mem_access_pkg::word_t retire_next;
    mem_access_pkg::word_t branch_next;
    mem_access_pkg::word_t pred_ok_next;

    // Clear wins over counting
    assign cycle_next   = clear ? '0 : cycle_cnt + 32'd1;
    assign retire_next  = clear ? '0 : retire_cnt + {31'h0, retire};
    assign branch_next  = clear ? '0 : branch_cnt + {31'h0, branch};
    assign pred_ok_next = clear ? '0 : pred_ok_cnt + {31'h0, branch_correct};

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt   <= '0;
            retire_cnt  <= '0;
            branch_cnt  <= '0;
            pred_ok_cnt <= '0;
        end else begin
            cycle_cnt   <= cycle_next;
            retire_cnt  <= retire_next;
            branch_cnt  <= branch_next;
            pred_ok_cnt <= pred_ok_next;
        end
    end

    // Read returns the value the counter takes at this edge
    always_ff @(posedge clk) begin
        if (rd) begin
            case (addr[7:0])
                mem_access_pkg::OFS_CYCLE:   rdata <= cycle_next;
                mem_access_pkg::OFS_RETIRE:  rdata <= retire_next;
                mem_access_pkg::OFS_BRANCH:  rdata <= branch_next;
                mem_access_pkg::OFS_PRED_OK: rdata <= pred_ok_next;
                default:                     rdata <= '0;
            endcase
        end
    end

    a_correct_is_branch: assert property (@(posedge clk) disable iff (rst)
        branch_correct |-> branch);

endmodule

`default_nettype wire

//--- verification/mem_access_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  mem_access_pkg::addr_t   paddr,
    input  mem_access_pkg::word_t   pwdata,
    input  mem_access_pkg::funct3_t funct3,
    input  mem_access_pkg::word_t   prdata,
    input  logic                    pready,
    input  logic                    pslverr,
    input  logic                    retire,
    input  logic                    branch,
    input  logic                    branch_correct,
    output int                      errors,
    output int                      checks
);
    mem_access_pkg::word_t ram_model [mem_access_pkg::DMEM_WORDS];
    mem_access_pkg::word_t rom_model [mem_access_pkg::ROM_WORDS];
    mem_access_pkg::word_t cnt_cycle = '0;
    mem_access_pkg::word_t cnt_retire = '0;
    mem_access_pkg::word_t cnt_branch = '0;
    mem_access_pkg::word_t cnt_pred = '0;
    mem_access_pkg::word_t read_word = '0;
    int                    acc_cycles = 0;
    int                    err_cnt = 0;
    int                    chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    initial begin
        $readmemh("bios.hex", rom_model);
    end

    function automatic logic bad_alignment(input mem_access_pkg::funct3_t f3,
                                           input logic [1:0] ofs);
        if (f3 == mem_access_pkg::F3_BYTE || f3 == mem_access_pkg::F3_BYTE_U) begin
            return 1'b0;
        end
        if (f3 == mem_access_pkg::F3_HALF || f3 == mem_access_pkg::F3_HALF_U) begin
            return ofs[0];
        end
        return !(f3 == mem_access_pkg::F3_WORD && ofs == 2'd0);
    endfunction

    function automatic mem_access_pkg::word_t store_merge(input mem_access_pkg::word_t old,
            input mem_access_pkg::word_t data, input logic [1:0] ofs,
            input mem_access_pkg::funct3_t f3);
        mem_access_pkg::word_t w;
        w = old;
        case (f3)
            mem_access_pkg::F3_BYTE, mem_access_pkg::F3_BYTE_U: w[8*ofs +: 8] = data[7:0];
            mem_access_pkg::F3_HALF, mem_access_pkg::F3_HALF_U: w[8*ofs +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    function automatic mem_access_pkg::word_t load_value(input mem_access_pkg::word_t w,
            input logic [1:0] ofs, input mem_access_pkg::funct3_t f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*ofs +: 8];
        h = ofs[1] ? w[31:16] : w[15:0];
        case (f3)
            mem_access_pkg::F3_BYTE:   return {{24{b[7]}}, b};
            mem_access_pkg::F3_HALF:   return {{16{h[15]}}, h};
            mem_access_pkg::F3_BYTE_U: return {24'h0, b};
            mem_access_pkg::F3_HALF_U: return {16'h0, h};
            mem_access_pkg::F3_WORD:   return w;
            default:                   return '0;
        endcase
    endfunction

    task automatic compare(input string name, input mem_access_pkg::word_t expected,
                           input mem_access_pkg::word_t actual);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Sampled mid-cycle so the model holds what the DUT will hold after the next edge
    always @(negedge clk) begin
        logic [3:0]            region;
        logic [7:0]            ofs8;
        logic                  ram_hit;
        logic                  rom_hit;
        logic                  mmio_hit;
        logic                  bad;
        logic                  first;
        logic                  clear;
        mem_access_pkg::word_t n_cycle;
        mem_access_pkg::word_t n_retire;
        mem_access_pkg::word_t n_branch;
        mem_access_pkg::word_t n_pred;
        mem_access_pkg::word_t cnt_word;
        region   = paddr[31:28];
        ofs8     = paddr[7:0];
        ram_hit  = (region == mem_access_pkg::REGION_DMEM_A) ||
                   (region == mem_access_pkg::REGION_DMEM_B);
        rom_hit  = (region == mem_access_pkg::REGION_BIOS);
        mmio_hit = (region == mem_access_pkg::REGION_MMIO);
        bad      = bad_alignment(funct3, paddr[1:0]) || (pwrite && rom_hit) ||
                   !(ram_hit || rom_hit || mmio_hit);
        first    = psel && penable && (acc_cycles == 0);
        clear    = first && pwrite && !bad && mmio_hit && (ofs8 == mem_access_pkg::OFS_CLEAR);
        if (rst || clear) begin
            n_cycle  = '0;
            n_retire = '0;
            n_branch = '0;
            n_pred   = '0;
        end else begin
            n_cycle  = cnt_cycle + 32'd1;
            n_retire = cnt_retire + {31'h0, retire};
            n_branch = cnt_branch + {31'h0, branch};
            n_pred   = cnt_pred + {31'h0, branch_correct};
        end
        case (ofs8)
            mem_access_pkg::OFS_CYCLE:   cnt_word = n_cycle;
            mem_access_pkg::OFS_RETIRE:  cnt_word = n_retire;
            mem_access_pkg::OFS_BRANCH:  cnt_word = n_branch;
            mem_access_pkg::OFS_PRED_OK: cnt_word = n_pred;
            default:                     cnt_word = '0;
        endcase

        if (rst || !(psel && penable)) begin
            compare("pready", 32'd0, {31'h0, pready});
            acc_cycles = 0;
        end else if (first) begin
            if (bad) begin
                compare("pready", 32'd1, {31'h0, pready});
                compare("pslverr", 32'd1, {31'h0, pslverr});
                compare("prdata", 32'd0, prdata);
            end else if (pwrite) begin
                compare("pready", 32'd1, {31'h0, pready});
                compare("pslverr", 32'd0, {31'h0, pslverr});
                if (ram_hit) begin
                    ram_model[paddr[11:2]] = store_merge(ram_model[paddr[11:2]], pwdata,
                                                         paddr[1:0], funct3);
                end
            end else begin
                // Read issue cycle with the response one cycle later
                compare("pready", 32'd0, {31'h0, pready});
                if (ram_hit) begin
                    read_word = ram_model[paddr[11:2]];
                end else if (rom_hit) begin
                    read_word = rom_model[paddr[5:2]];
                end else begin
                    read_word = cnt_word;
                end
            end
            acc_cycles = pready ? 0 : 1;
        end else if (acc_cycles == 1) begin
            compare("pready", 32'd1, {31'h0, pready});
            compare("pslverr", 32'd0, {31'h0, pslverr});
            compare("prdata", load_value(read_word, paddr[1:0], funct3), prdata);
            acc_cycles = pready ? 0 : 2;
        end else begin
            err_cnt++;
            $display("Transfer to %h still waiting after its wait state at %0t", paddr, $time);
            acc_cycles = pready ? 0 : acc_cycles + 1;
        end

        cnt_cycle  = n_cycle;
        cnt_retire = n_retire;
        cnt_branch = n_branch;
        cnt_pred   = n_pred;
    end

endmodule

`default_nettype wire

//--- verification/mem_access_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_tb;
    localparam int TRANSFERS  = 400;
    localparam int WAIT_LIMIT = 8;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    mem_access_pkg::addr_t   paddr;
    mem_access_pkg::word_t   pwdata;
    mem_access_pkg::funct3_t funct3;
    mem_access_pkg::word_t   prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    retire;
    logic                    branch;
    logic                    branch_correct;
    logic [31:0]             lfsr = 32'd81;
    logic                    timed_out = 1'b0;
    int                      errors;
    int                      checks;

    mem_access_top dut (
        .clk            (clk),
        .rst            (rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .funct3         (funct3),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .retire         (retire),
        .branch         (branch),
        .branch_correct (branch_correct)
    );

    mem_access_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .funct3         (funct3),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .retire         (retire),
        .branch         (branch),
        .branch_correct (branch_correct),
        .errors         (errors),
        .checks         (checks)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
        return value;
    endfunction

    // Step to just after the next rising edge and refresh the core events
    task automatic next_cycle();
        logic [2:0] ev;
        @(posedge clk);
        #1;
        ev = rst ? 3'b000 : 3'(rand_bits(3));
        retire         = ev[0];
        branch         = ev[1];
        branch_correct = ev[1] & ev[2];
    endtask

    task automatic apb_transfer(input logic wr, input mem_access_pkg::addr_t addr,
                                input mem_access_pkg::word_t data,
                                input mem_access_pkg::funct3_t f3);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        funct3  = f3;
        next_cycle();
        penable = 1'b1;
        while (!done && !timed_out) begin
            @(negedge clk);
            if (pready) begin
                done = 1'b1;
            end else if (waited == WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout at %0t: no pready for address %h", $time, addr);
            end
            waited++;
            next_cycle();
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Mostly RAM, ROM and counters with an unmapped nibble now and then
    task automatic random_transfer();
        logic                  wr;
        logic [2:0]            sel;
        logic [2:0]            pick;
        logic [5:0]            ofs;
        mem_access_pkg::addr_t addr;
        wr   = 1'(rand_bits(1));
        sel  = 3'(rand_bits(3));
        pick = 3'(rand_bits(3));
        ofs  = 6'(rand_bits(6));
        case (sel)
            3'd0, 3'd1, 3'd2: begin
                addr = {(sel[0] ? mem_access_pkg::REGION_DMEM_B : mem_access_pkg::REGION_DMEM_A),
                        22'h0, ofs};
            end
            3'd3, 3'd4: addr = {mem_access_pkg::REGION_BIOS, 22'h0, ofs};
            3'd5, 3'd6: addr = {mem_access_pkg::REGION_MMIO, 20'h0, 8'h0C + {3'b000, pick, 2'b00}};
            default:    addr = {pick[1:0], 2'b10, 22'h0, ofs};
        endcase
        apb_transfer(wr, addr, rand_bits(32), 3'(rand_bits(3)));
    endtask

    initial begin
        rst            = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        funct3         = mem_access_pkg::F3_WORD;
        retire         = 1'b0;
        branch         = 1'b0;
        branch_correct = 1'b0;
        repeat (3) next_cycle();
        rst = 1'b0;
        // Fill the RAM window so every later load hits known data
        for (int i = 0; i < 16 && !timed_out; i++) begin
            apb_transfer(1'b1, {mem_access_pkg::REGION_DMEM_A, 22'h0, i[3:0], 2'b00},
                         rand_bits(32), mem_access_pkg::F3_WORD);
        end
        for (int n = 0; n < TRANSFERS && !timed_out; n++) begin
            random_transfer();
        end
        next_cycle();
        next_cycle();
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timed_out);
        if (errors == 0 && checks > 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
